// ==== all.f ====
rtl/btb_pkg.sv
rtl/btb_array.sv
rtl/btb_arbiter.sv
rtl/btb_lookup.sv
rtl/btb_update.sv
rtl/btb_top.sv
tests/tb_btb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the branch target buffer testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=sim_btb

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -f all.f --top-module tb_btb -Mdir "$BUILD_DIR" -o "$SIM"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "FAIL: see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "PASS"
exit 0

// ==== tests/tb_btb.sv ====
/*
 * Testbench for the branch target buffer.
 * Clock and reset, a per-set reference model, compare tasks,
 * directed cases, a seeded random mix and a watchdog.
 */
module tb_btb import btb_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - 2;
    localparam int SETS       = 1 << INDEX_W;
    localparam int CLK_PERIOD = 8;
    localparam int N_DIRECTED = 24;
    localparam int N_RANDOM   = 400;
    // worst case per operation including a wait behind the other engine.
    localparam int OP_CYCLES  = 20;
    localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM + 2) * OP_CYCLES * CLK_PERIOD;

    logic              CLK;
    logic              rst;
    logic              lookup_valid;
    logic [ADDR_W-1:0] lookup_pc;
    logic              upd_valid;
    logic [ADDR_W-1:0] upd_pc;
    logic              upd_taken;
    logic [ADDR_W-1:0] upd_target;
    logic              lookup_ready;
    logic              resp_valid;
    logic              resp_hit;
    logic [ADDR_W-1:0] resp_target;
    logic              upd_ready;

    // reference model state per way and set.
    logic              m_valid  [2][SETS];
    logic [TAG_W-1:0]  m_tag    [2][SETS];
    logic [ADDR_W-1:0] m_target [2][SETS];
    logic              m_lru    [SETS];

    btb_top #(.INDEX_W(INDEX_W)) i_btb_top (
        .CLK, .rst,
        .lookup_valid, .lookup_pc, .upd_valid, .upd_pc, .upd_taken, .upd_target,
        .lookup_ready, .resp_valid, .resp_hit, .resp_target, .upd_ready
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the operations did not complete within %0d ns", TIMEOUT_NS);
        stop_run();
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic void model_reset();
        for (int s = 0; s < SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
    endfunction

    // matching valid way or -1.
    function automatic int find_way(input logic [INDEX_W-1:0] idx, input logic [TAG_W-1:0] tag);
        if (m_valid[0][idx] && (m_tag[0][idx] == tag)) return 0;
        if (m_valid[1][idx] && (m_tag[1][idx] == tag)) return 1;
        return -1;
    endfunction

    function automatic void model_lookup(input logic [ADDR_W-1:0] pc, output logic hit,
                                         output logic [ADDR_W-1:0] target);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        int                 w;
        idx    = pc[INDEX_W+1:2];
        tag    = pc[ADDR_W-1:INDEX_W+2];
        w      = find_way(idx, tag);
        hit    = (w >= 0);
        target = '0;
        if (w >= 0) begin
            target     = m_target[w][idx];
            // the victim becomes the way not just used.
            m_lru[idx] = (w == 0);
        end
    endfunction

    function automatic void model_update(input logic [ADDR_W-1:0] pc, input logic taken,
                                         input logic [ADDR_W-1:0] target);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        int                 w;
        idx = pc[INDEX_W+1:2];
        tag = pc[ADDR_W-1:INDEX_W+2];
        w   = find_way(idx, tag);
        if (taken) begin
            if (w < 0) begin
                if (!m_valid[0][idx]) w = 0;
                else if (!m_valid[1][idx]) w = 1;
                else w = m_lru[idx] ? 1 : 0;
            end
            m_valid[w][idx]  = 1'b1;
            m_tag[w][idx]    = tag;
            m_target[w][idx] = target;
            m_lru[idx]       = (w == 0);
        end else if (w >= 0) begin
            m_valid[w][idx] = 1'b0;
        end
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_resp(input string name, input logic exp_hit,
                              input logic [ADDR_W-1:0] exp_target, input logic act_hit,
                              input logic [ADDR_W-1:0] act_target);
        if ((act_hit !== exp_hit) || (act_target !== exp_target)) begin
            $display("Mismatch %s: expected hit=%0b target=%08h, actual hit=%0b target=%08h",
                     name, exp_hit, exp_target, act_hit, act_target);
            stop_run();
        end
    endtask

    // status bits are lookup_ready, upd_ready, resp_valid.
    task automatic check_status(input string name, input logic [2:0] exp_status,
                                input logic [2:0] act_status);
        if (act_status !== exp_status) begin
            $display("Mismatch %s: expected ready/ready/resp=%03b, actual ready/ready/resp=%03b",
                     name, exp_status, act_status);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    function automatic logic [ADDR_W-1:0] make_pc(input int unsigned tag_sel,
                                                  input int unsigned idx);
        return 32'h0040_0000 + (tag_sel << (INDEX_W + 2)) + (idx << 2);
    endfunction

    // few tags over few sets so that sets fill and collide.
    function automatic logic [ADDR_W-1:0] pool_pc();
        int unsigned tag_sel;
        int unsigned idx;
        tag_sel = $urandom_range(0, 3);
        idx     = $urandom_range(0, 3);
        return make_pc(tag_sel, idx);
    endfunction

    // launches on a falling edge and then waits until both engines are idle.
    task automatic run_op(input string name, input bit do_lk, input logic [ADDR_W-1:0] lk_pc,
                          input bit do_up, input logic [ADDR_W-1:0] up_pc, input logic up_tk,
                          input logic [ADDR_W-1:0] up_tgt);
        logic              exp_hit;
        logic [ADDR_W-1:0] exp_target;
        bit                got_resp;
        got_resp   = 1'b0;
        exp_hit    = 1'b0;
        exp_target = '0;
        // the update wins the array first.
        if (do_up) model_update(up_pc, up_tk, up_tgt);
        if (do_lk) model_lookup(lk_pc, exp_hit, exp_target);
        lookup_valid = do_lk;
        lookup_pc    = lk_pc;
        upd_valid    = do_up;
        upd_pc       = up_pc;
        upd_taken    = up_tk;
        upd_target   = up_tgt;
        @(negedge CLK);
        lookup_valid = 1'b0;
        upd_valid    = 1'b0;
        while (!(lookup_ready && upd_ready && (got_resp || !do_lk))) begin
            if (resp_valid) begin
                if (!do_lk || got_resp) begin
                    $display("Unexpected response during %s", name);
                    stop_run();
                end
                check_resp(name, exp_hit, exp_target, resp_hit, resp_target);
                got_resp = 1'b1;
            end
            @(negedge CLK);
        end
        if (resp_valid) begin
            $display("Response held high for more than one cycle in %s", name);
            stop_run();
        end
    endtask

    task automatic lookup_op(input string name, input logic [ADDR_W-1:0] pc);
        run_op(name, 1'b1, pc, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic update_op(input string name, input logic [ADDR_W-1:0] pc, input logic taken,
                             input logic [ADDR_W-1:0] target);
        run_op(name, 1'b0, '0, 1'b1, pc, taken, target);
    endtask

    task automatic pair_op(input string name, input logic [ADDR_W-1:0] up_pc, input logic taken,
                           input logic [ADDR_W-1:0] target, input logic [ADDR_W-1:0] lk_pc);
        run_op(name, 1'b1, lk_pc, 1'b1, up_pc, taken, target);
    endtask

    initial begin
        int unsigned       kind;
        logic [ADDR_W-1:0] pc_a;
        logic [ADDR_W-1:0] pc_b;
        logic [ADDR_W-1:0] lk_pc;
        logic              taken;
        logic [ADDR_W-1:0] target;
        void'($urandom(29));
        rst          = 1'b1;
        lookup_valid = 1'b0;
        lookup_pc    = '0;
        upd_valid    = 1'b0;
        upd_pc       = '0;
        upd_taken    = 1'b0;
        upd_target   = '0;
        model_reset();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        @(negedge CLK);
        check_status("after reset", 3'b110, {lookup_ready, upd_ready, resp_valid});

        // empty buffer.
        lookup_op("reset miss", make_pc(0, 0));
        lookup_op("reset miss", make_pc(1, 5));
        lookup_op("reset miss", make_pc(7, 15));

        // install and then replace in place next to a second entry.
        update_op("install", make_pc(1, 2), 1'b1, 32'h0000_1a40);
        lookup_op("install hit", make_pc(1, 2));
        update_op("retarget", make_pc(1, 2), 1'b1, 32'h0000_2b80);
        lookup_op("retarget hit", make_pc(1, 2));
        update_op("second way", make_pc(2, 2), 1'b1, 32'h0000_3c00);
        update_op("retarget again", make_pc(1, 2), 1'b1, 32'h0000_4d10);
        lookup_op("neighbour kept", make_pc(2, 2));
        lookup_op("retarget again hit", make_pc(1, 2));

        // three tags in set 5; the touched entry survives.
        update_op("lru fill", make_pc(1, 5), 1'b1, 32'h0001_0000);
        update_op("lru fill", make_pc(2, 5), 1'b1, 32'h0002_0000);
        lookup_op("lru touch", make_pc(1, 5));
        update_op("lru evict", make_pc(3, 5), 1'b1, 32'h0003_0000);
        lookup_op("lru survivor", make_pc(1, 5));
        lookup_op("lru victim", make_pc(2, 5));
        lookup_op("lru newcomer", make_pc(3, 5));

        // not taken removes a match and only a match, here with both ways full.
        update_op("invalidate no match", make_pc(4, 5), 1'b0, 32'h0);
        lookup_op("no match kept", make_pc(1, 5));
        update_op("invalidate", make_pc(3, 5), 1'b0, 32'h0);
        lookup_op("invalidated miss", make_pc(3, 5));

        // same-cycle update and lookup.
        pair_op("pair install", make_pc(4, 5), 1'b1, 32'h0004_0000, make_pc(4, 5));
        pair_op("pair invalidate", make_pc(1, 5), 1'b0, 32'h0, make_pc(1, 5));

        for (int n = 0; n < N_RANDOM; n++) begin
            kind   = $urandom_range(0, 9);
            pc_a   = pool_pc();
            pc_b   = pool_pc();
            taken  = ($urandom_range(0, 3) != 0);
            target = $urandom;
            lk_pc  = ($urandom_range(0, 1) != 0) ? pc_a : pc_b;
            if (kind < 4) begin
                lookup_op($sformatf("random lookup %0d", n), pc_a);
            end else if (kind < 7) begin
                update_op($sformatf("random update %0d", n), pc_a, taken, target);
            end else begin
                pair_op($sformatf("random pair %0d", n), pc_a, taken, target, lk_pc);
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== rtl/btb_top.sv ====
/*
 * Branch target buffer top level.
 * Lookup and update engines sharing one set array
 * through the arbiter.
 */
module btb_top import btb_pkg::*; #(
    parameter int INDEX_W = 10,
    localparam int TAG_W = ADDR_W - INDEX_W - 2
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              lookup_valid,
    input  logic [ADDR_W-1:0] lookup_pc,
    input  logic              upd_valid,
    input  logic [ADDR_W-1:0] upd_pc,
    input  logic              upd_taken,
    input  logic [ADDR_W-1:0] upd_target,
    output logic              lookup_ready,
    output logic              resp_valid,
    output logic              resp_hit,
    output logic [ADDR_W-1:0] resp_target,
    output logic              upd_ready
);

    // lookup engine side.
    logic               lk_req;
    logic               lk_gnt;
    logic               lk_en;
    logic               lk_we;
    logic [INDEX_W-1:0] lk_index;
    btb_way_e           lk_wr_way;
    logic [TAG_W-1:0]   lk_wr_tag;
    logic [ADDR_W-1:0]  lk_wr_target;
    logic               lk_wr_valid;
    logic               lk_wr_lru;

    // update engine side.
    logic               up_req;
    logic               up_gnt;
    logic               up_en;
    logic               up_we;
    logic [INDEX_W-1:0] up_index;
    btb_way_e           up_wr_way;
    logic [TAG_W-1:0]   up_wr_tag;
    logic [ADDR_W-1:0]  up_wr_target;
    logic               up_wr_valid;
    logic               up_wr_lru;

    // array port and read data.
    logic               arr_en;
    logic               arr_we;
    logic [INDEX_W-1:0] arr_index;
    btb_way_e           arr_wr_way;
    logic [TAG_W-1:0]   arr_wr_tag;
    logic [ADDR_W-1:0]  arr_wr_target;
    logic               arr_wr_valid;
    logic               arr_wr_lru;
    logic [TAG_W-1:0]   rd_tag0;
    logic [TAG_W-1:0]   rd_tag1;
    logic [ADDR_W-1:0]  rd_target0;
    logic [ADDR_W-1:0]  rd_target1;
    logic               rd_valid0;
    logic               rd_valid1;
    logic               rd_lru;

    btb_lookup #(.INDEX_W(INDEX_W)) i_btb_lookup (
        .CLK, .rst, .lookup_valid, .lookup_pc, .gnt(lk_gnt),
        .rd_tag0, .rd_tag1, .rd_target0, .rd_target1, .rd_valid0, .rd_valid1, .rd_lru,
        .lookup_ready, .resp_valid, .resp_hit, .resp_target,
        .req(lk_req), .en(lk_en), .we(lk_we), .index(lk_index),
        .wr_way(lk_wr_way), .wr_tag(lk_wr_tag), .wr_target(lk_wr_target),
        .wr_valid(lk_wr_valid), .wr_lru(lk_wr_lru)
    );

    btb_update #(.INDEX_W(INDEX_W)) i_btb_update (
        .CLK, .rst, .upd_valid, .upd_pc, .upd_taken, .upd_target, .gnt(up_gnt),
        .rd_tag0, .rd_tag1, .rd_target0, .rd_target1, .rd_valid0, .rd_valid1, .rd_lru,
        .upd_ready,
        .req(up_req), .en(up_en), .we(up_we), .index(up_index),
        .wr_way(up_wr_way), .wr_tag(up_wr_tag), .wr_target(up_wr_target),
        .wr_valid(up_wr_valid), .wr_lru(up_wr_lru)
    );

    btb_arbiter #(.INDEX_W(INDEX_W)) i_btb_arbiter (
        .CLK, .rst, .lk_req, .up_req,
        .lk_en, .lk_we, .lk_index, .lk_wr_way, .lk_wr_tag, .lk_wr_target,
        .lk_wr_valid, .lk_wr_lru,
        .up_en, .up_we, .up_index, .up_wr_way, .up_wr_tag, .up_wr_target,
        .up_wr_valid, .up_wr_lru,
        .lk_gnt, .up_gnt,
        .arr_en, .arr_we, .arr_index, .arr_wr_way, .arr_wr_tag, .arr_wr_target,
        .arr_wr_valid, .arr_wr_lru
    );

    btb_array #(.INDEX_W(INDEX_W)) i_btb_array (
        .CLK, .rst,
        .arr_en, .arr_we, .arr_index, .arr_wr_way, .arr_wr_tag, .arr_wr_target,
        .arr_wr_valid, .arr_wr_lru,
        .rd_tag0, .rd_tag1, .rd_target0, .rd_target1, .rd_valid0, .rd_valid1, .rd_lru
    );

endmodule

// ==== rtl/btb_update.sv ====
/*
 * Branch resolution update engine.
 * Taken branches install or refresh their target in the
 * matching way, else an invalid way, else the LRU victim.
 * Not-taken branches invalidate a matching entry.
 */
module btb_update import btb_pkg::*; #(
    parameter int INDEX_W = 10,
    localparam int TAG_W = ADDR_W - INDEX_W - 2
) (
    input  logic               CLK,
    input  logic               rst,
    input  logic               upd_valid,
    input  logic [ADDR_W-1:0]  upd_pc,
    input  logic               upd_taken,
    input  logic [ADDR_W-1:0]  upd_target,
    input  logic               gnt,
    input  logic [TAG_W-1:0]   rd_tag0,
    input  logic [TAG_W-1:0]   rd_tag1,
    input  logic [ADDR_W-1:0]  rd_target0,
    input  logic [ADDR_W-1:0]  rd_target1,
    input  logic               rd_valid0,
    input  logic               rd_valid1,
    input  logic               rd_lru,
    output logic               upd_ready,
    output logic               req,
    output logic               en,
    output logic               we,
    output logic [INDEX_W-1:0] index,
    output btb_way_e           wr_way,
    output logic [TAG_W-1:0]   wr_tag,
    output logic [ADDR_W-1:0]  wr_target,
    output logic               wr_valid,
    output logic               wr_lru
);

    btb_eng_state_e     state;
    logic [INDEX_W-1:0] index_q;
    logic [TAG_W-1:0]   tag_q;
    logic               taken_q;
    logic [ADDR_W-1:0]  target_q;
    logic               match0;
    logic               match1;
    logic               match;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:     if (upd_valid) state <= ST_WAIT_GNT;
                ST_WAIT_GNT: if (gnt) state <= ST_READ;
                ST_READ:     state <= ST_WRITE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // resolution payload.
    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && upd_valid) begin
            index_q  <= upd_pc[INDEX_W+1:2];
            tag_q    <= upd_pc[ADDR_W-1:INDEX_W+2];
            taken_q  <= upd_taken;
            target_q <= upd_target;
        end
    end

    assign match0 = rd_valid0 && (rd_tag0 == tag_q);
    assign match1 = rd_valid1 && (rd_tag1 == tag_q);
    assign match  = match0 || match1;

    //////////////////////////////////////////////////
    // way choice: match, free way, then lru victim
    //////////////////////////////////////////////////

    always_comb begin
        if (match0) begin
            wr_way = WAY0;
        end else if (match1) begin
            wr_way = WAY1;
        end else if (!rd_valid0) begin
            wr_way = WAY0;
        end else if (!rd_valid1) begin
            wr_way = WAY1;
        end else begin
            wr_way = btb_way_e'(rd_lru);
        end
    end

    assign upd_ready = (state == ST_IDLE);
    assign req       = (state != ST_IDLE);

    // taken always writes, not-taken only when it finds a match.
    assign en    = (state == ST_READ) || ((state == ST_WRITE) && (taken_q || match));
    assign we    = (state == ST_WRITE);
    assign index = index_q;

    assign wr_tag    = tag_q;
    assign wr_valid  = taken_q;
    assign wr_target = taken_q ? target_q : (match0 ? rd_target0 : rd_target1);
    // an invalidate keeps the set's lru as it was.
    assign wr_lru    = taken_q ? (wr_way == WAY0) : rd_lru;

endmodule

// ==== rtl/btb_lookup.sv ====
/*
 * Fetch-side lookup engine.
 * Latches the query PC, reads its set through the arbiter,
 * compares the tag against both valid ways and responds.
 * A hit rewrites the hit way with LRU pointing at the other.
 */
module btb_lookup import btb_pkg::*; #(
    parameter int INDEX_W = 10,
    localparam int TAG_W = ADDR_W - INDEX_W - 2
) (
    input  logic               CLK,
    input  logic               rst,
    input  logic               lookup_valid,
    input  logic [ADDR_W-1:0]  lookup_pc,
    input  logic               gnt,
    input  logic [TAG_W-1:0]   rd_tag0,
    input  logic [TAG_W-1:0]   rd_tag1,
    input  logic [ADDR_W-1:0]  rd_target0,
    input  logic [ADDR_W-1:0]  rd_target1,
    input  logic               rd_valid0,
    input  logic               rd_valid1,
    input  logic               rd_lru,
    output logic               lookup_ready,
    output logic               resp_valid,
    output logic               resp_hit,
    output logic [ADDR_W-1:0]  resp_target,
    output logic               req,
    output logic               en,
    output logic               we,
    output logic [INDEX_W-1:0] index,
    output btb_way_e           wr_way,
    output logic [TAG_W-1:0]   wr_tag,
    output logic [ADDR_W-1:0]  wr_target,
    output logic               wr_valid,
    output logic               wr_lru
);

    btb_eng_state_e     state;
    logic [INDEX_W-1:0] index_q;
    logic [TAG_W-1:0]   tag_q;
    logic               hit0;
    logic               hit1;
    logic               hit;
    logic [ADDR_W-1:0]  hit_target;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:     if (lookup_valid) state <= ST_WAIT_GNT;
                ST_WAIT_GNT: if (gnt) state <= ST_READ;
                ST_READ:     state <= ST_WRITE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // split the pc into set index and tag.
    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && lookup_valid) begin
            index_q <= lookup_pc[INDEX_W+1:2];
            tag_q   <= lookup_pc[ADDR_W-1:INDEX_W+2];
        end
    end

    //////////////////////////////////////////////////
    // tag compare with way 0 winning a double hit
    //////////////////////////////////////////////////

    assign hit0       = rd_valid0 && (rd_tag0 == tag_q);
    assign hit1       = rd_valid1 && (rd_tag1 == tag_q);
    assign hit        = hit0 || hit1;
    assign wr_way     = hit0 ? WAY0 : WAY1;
    assign hit_target = hit0 ? rd_target0 : rd_target1;

    assign lookup_ready = (state == ST_IDLE);
    assign req          = (state != ST_IDLE);
    assign resp_valid   = (state == ST_WRITE);
    assign resp_hit     = resp_valid && hit;
    assign resp_target  = resp_hit ? hit_target : '0;

    // a hit rewrites the same entry with lru naming the other way.
    assign en        = (state == ST_READ) || (resp_valid && hit);
    assign we        = (state == ST_WRITE);
    assign index     = index_q;
    assign wr_tag    = tag_q;
    assign wr_target = hit_target;
    assign wr_valid  = 1'b1;
    assign wr_lru    = (wr_way == WAY0) ? 1'b1 : 1'b0;

endmodule

// ==== rtl/btb_arbiter.sv ====
/*
 * Array port arbiter.
 * Grants the single array port to the lookup or the update
 * engine, update first when free, and holds the grant until
 * the owner drops its request. Steers the owner's signals.
 */
module btb_arbiter import btb_pkg::*; #(
    parameter int INDEX_W = 10,
    localparam int TAG_W = ADDR_W - INDEX_W - 2
) (
    input  logic               CLK,
    input  logic               rst,
    input  logic               lk_req,
    input  logic               up_req,
    input  logic               lk_en,
    input  logic               lk_we,
    input  logic [INDEX_W-1:0] lk_index,
    input  btb_way_e           lk_wr_way,
    input  logic [TAG_W-1:0]   lk_wr_tag,
    input  logic [ADDR_W-1:0]  lk_wr_target,
    input  logic               lk_wr_valid,
    input  logic               lk_wr_lru,
    input  logic               up_en,
    input  logic               up_we,
    input  logic [INDEX_W-1:0] up_index,
    input  btb_way_e           up_wr_way,
    input  logic [TAG_W-1:0]   up_wr_tag,
    input  logic [ADDR_W-1:0]  up_wr_target,
    input  logic               up_wr_valid,
    input  logic               up_wr_lru,
    output logic               lk_gnt,
    output logic               up_gnt,
    output logic               arr_en,
    output logic               arr_we,
    output logic [INDEX_W-1:0] arr_index,
    output btb_way_e           arr_wr_way,
    output logic [TAG_W-1:0]   arr_wr_tag,
    output logic [ADDR_W-1:0]  arr_wr_target,
    output logic               arr_wr_valid,
    output logic               arr_wr_lru
);

    btb_req_e owner_q;
    logic     busy_q;
    btb_req_e sel;
    logic     hold;
    logic     grant;

    // holder keeps the port while its request stays up.
    always_comb begin
        hold = busy_q && ((owner_q == REQ_UPDATE) ? up_req : lk_req);
        if (hold) begin
            sel = owner_q;
        end else if (up_req) begin
            sel = REQ_UPDATE;
        end else begin
            sel = REQ_LOOKUP;
        end
        grant = hold || up_req || lk_req;
    end

    assign lk_gnt = grant && (sel == REQ_LOOKUP);
    assign up_gnt = grant && (sel == REQ_UPDATE);

    always_ff @(posedge CLK) begin
        if (rst) begin
            busy_q  <= 1'b0;
            owner_q <= REQ_LOOKUP;
        end else begin
            busy_q  <= grant;
            owner_q <= sel;
        end
    end

    //////////////////////////////////////////////////
    // array port steering
    //////////////////////////////////////////////////

    always_comb begin
        if (sel == REQ_UPDATE) begin
            arr_en        = grant && up_en;
            arr_we        = up_we;
            arr_index     = up_index;
            arr_wr_way    = up_wr_way;
            arr_wr_tag    = up_wr_tag;
            arr_wr_target = up_wr_target;
            arr_wr_valid  = up_wr_valid;
            arr_wr_lru    = up_wr_lru;
        end else begin
            arr_en        = grant && lk_en;
            arr_we        = lk_we;
            arr_index     = lk_index;
            arr_wr_way    = lk_wr_way;
            arr_wr_tag    = lk_wr_tag;
            arr_wr_target = lk_wr_target;
            arr_wr_valid  = lk_wr_valid;
            arr_wr_lru    = lk_wr_lru;
        end
    end

endmodule

// ==== rtl/btb_array.sv ====
/*
 * Two-way set storage of the branch target buffer.
 * Tag and target memory per way, valid bits per way and
 * one LRU bit per set. One access per cycle; a read
 * returns the whole set on the following cycle.
 */
module btb_array import btb_pkg::*; #(
    parameter int INDEX_W = 10,
    localparam int TAG_W = ADDR_W - INDEX_W - 2
) (
    input  logic               CLK,
    input  logic               rst,
    input  logic               arr_en,
    input  logic               arr_we,
    input  logic [INDEX_W-1:0] arr_index,
    input  btb_way_e           arr_wr_way,
    input  logic [TAG_W-1:0]   arr_wr_tag,
    input  logic [ADDR_W-1:0]  arr_wr_target,
    input  logic               arr_wr_valid,
    input  logic               arr_wr_lru,
    output logic [TAG_W-1:0]   rd_tag0,
    output logic [TAG_W-1:0]   rd_tag1,
    output logic [ADDR_W-1:0]  rd_target0,
    output logic [ADDR_W-1:0]  rd_target1,
    output logic               rd_valid0,
    output logic               rd_valid1,
    output logic               rd_lru
);

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]  tag_mem0 [SETS];
    logic [TAG_W-1:0]  tag_mem1 [SETS];
    logic [ADDR_W-1:0] tgt_mem0 [SETS];
    logic [ADDR_W-1:0] tgt_mem1 [SETS];
    logic [SETS-1:0]   valid0;
    logic [SETS-1:0]   valid1;
    logic [SETS-1:0]   lru;
    logic              wr_fire;
    logic              rd_fire;

    assign wr_fire = arr_en && arr_we;
    assign rd_fire = arr_en && !arr_we;

    // tag and target payload, one way per write.
    always_ff @(posedge CLK) begin
        if (wr_fire) begin
            if (arr_wr_way == WAY0) begin
                tag_mem0[arr_index] <= arr_wr_tag;
                tgt_mem0[arr_index] <= arr_wr_target;
            end else begin
                tag_mem1[arr_index] <= arr_wr_tag;
                tgt_mem1[arr_index] <= arr_wr_target;
            end
        end
    end

    // valid of the written way; lru of the set on every write.
    always_ff @(posedge CLK) begin
        if (rst) begin
            valid0 <= '0;
            valid1 <= '0;
            lru    <= '0;
        end else if (wr_fire) begin
            if (arr_wr_way == WAY0) begin
                valid0[arr_index] <= arr_wr_valid;
            end else begin
                valid1[arr_index] <= arr_wr_valid;
            end
            lru[arr_index] <= arr_wr_lru;
        end
    end

    // registered set read.
    always_ff @(posedge CLK) begin
        if (rd_fire) begin
            rd_tag0    <= tag_mem0[arr_index];
            rd_tag1    <= tag_mem1[arr_index];
            rd_target0 <= tgt_mem0[arr_index];
            rd_target1 <= tgt_mem1[arr_index];
            rd_valid0  <= valid0[arr_index];
            rd_valid1  <= valid1[arr_index];
            rd_lru     <= lru[arr_index];
        end
    end

endmodule

// ==== rtl/btb_pkg.sv ====
/*
 * Shared definitions for the branch target buffer.
 * Address width, way names, requester names and the
 * engine state encoding used by both engines.
 */
package btb_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // instruction address width.
    localparam int ADDR_W = 32;

    //////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////

    // the two ways of a set.
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } btb_way_e;

    // who owns the array port.
    typedef enum logic {
        REQ_LOOKUP = 1'b0,
        REQ_UPDATE = 1'b1
    } btb_req_e;

    // engine sequence: accept, wait for grant, read, then write or respond.
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_WAIT_GNT = 2'd1,
        ST_READ     = 2'd2,
        ST_WRITE    = 2'd3
    } btb_eng_state_e;

endpackage
